//--- hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path
`define CORE_XLEN 32

// register counts and buffer depth
`define CORE_ARCH_REGS 32
`define CORE_ROB_DEPTH 8

// one spare tag per buffer entry keeps the free list from running dry
`define CORE_PHYS_REGS (`CORE_ARCH_REGS + `CORE_ROB_DEPTH)

// index widths
`define CORE_ARCH_W 5
`define CORE_PHYS_W 6
`define CORE_ROB_W  3

`endif

//--- hdl/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [`CORE_ARCH_W-1:0] rs2;
        logic [`CORE_ARCH_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_ARCH_W-1:0] rd;
        logic [6:0]              opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0]             imm12;
        logic [`CORE_ARCH_W-1:0] rs1;
        logic [2:0]              funct3;
        logic [`CORE_ARCH_W-1:0] rd;
        logic [6:0]              opcode;
    } i_fields_t;

    // same word, register or immediate format
    typedef union packed {
        r_fields_t r_view;
        i_fields_t i_view;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        logic                    uses_imm;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_ARCH_W-1:0] rs1;
        logic [`CORE_ARCH_W-1:0] rs2;
        logic [`CORE_ARCH_W-1:0] rd;
        logic                    writes_rd;
    } dec_uop_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        logic                    uses_imm;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_PHYS_W-1:0] prs1;
        logic [`CORE_PHYS_W-1:0] prs2;
        logic [`CORE_PHYS_W-1:0] prd;
        logic [`CORE_PHYS_W-1:0] old_prd;
        logic                    writes_rd;
        logic [`CORE_ARCH_W-1:0] rd;
        logic [`CORE_ROB_W-1:0]  rob_idx;
    } ren_uop_t;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_ROB_W-1:0] rob_idx;
        logic [`CORE_XLEN-1:0]  value;
    } exe_result_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_ARCH_W-1:0] rd;
        logic                    writes_rd;
        logic [`CORE_XLEN-1:0]   value;
    } retire_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_PHYS_W-1:0] tag;
    } free_t;

endpackage

//--- hdl/decode_stage.sv
`include "core_settings.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rstn,
    input  logic               instr_valid,
    input  core_pkg::instr_t   instr,
    output core_pkg::dec_uop_t uop
);
    logic [`CORE_XLEN-1:0] pc_q;
    core_pkg::dec_uop_t    dec;
    logic                  legal;
    logic                  alt; // sub / sra select
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [11:0]           imm12;

    assign funct3 = instr.r_view.funct3;
    assign funct7 = instr.r_view.funct7;
    assign imm12  = instr.i_view.imm12;

    always_comb begin
        dec           = '0;
        dec.pc        = pc_q;
        dec.rs1       = instr.r_view.rs1;
        dec.rd        = instr.r_view.rd;
        dec.writes_rd = (instr.r_view.rd != '0);
        alt           = 1'b0;
        case (instr.r_view.opcode)
            core_pkg::OPC_OP: begin
                dec.rs2 = instr.r_view.rs2;
                alt     = funct7[5];
                legal   = (funct7 == 7'b0000000) ||
                          ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            core_pkg::OPC_OP_IMM: begin
                dec.uses_imm = 1'b1;
                dec.imm      = {{(`CORE_XLEN-12){imm12[11]}}, imm12};
                alt          = (funct3 == 3'b101) && imm12[10];
                case (funct3)
                    3'b001:  legal = (imm12[11:5] == 7'b0000000);
                    3'b101:  legal = (imm12[11:5] == 7'b0000000) || (imm12[11:5] == 7'b0100000);
                    default: legal = 1'b1;
                endcase
            end
            default: legal = 1'b0;
        endcase
        case (funct3)
            3'b000:  dec.alu_op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  dec.alu_op = core_pkg::ALU_SLL;
            3'b010:  dec.alu_op = core_pkg::ALU_SLT;
            3'b011:  dec.alu_op = core_pkg::ALU_SLTU;
            3'b100:  dec.alu_op = core_pkg::ALU_XOR;
            3'b101:  dec.alu_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  dec.alu_op = core_pkg::ALU_OR;
            default: dec.alu_op = core_pkg::ALU_AND;
        endcase
        dec.valid = instr_valid && legal; // unsupported words drop out here
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q <= '0;
            uop  <= '0;
        end else begin
            uop <= dec;
            if (instr_valid) begin
                pc_q <= pc_q + 'd4; // slot used even when dropped
            end
        end
    end

endmodule

//--- hdl/rename_stage.sv
`include "core_settings.svh"

module rename_stage (
    input  logic               clk,
    input  logic               rstn,
    input  core_pkg::dec_uop_t dec,
    input  core_pkg::free_t    release_tag,
    output core_pkg::ren_uop_t uop
);
    localparam int unsigned PHYS_W = `CORE_PHYS_W;
    localparam int unsigned ROB_W  = `CORE_ROB_W;

    logic [PHYS_W-1:0] map_q [`CORE_ARCH_REGS];
    logic [PHYS_W-1:0] free_q [`CORE_ROB_DEPTH];
    logic [ROB_W-1:0]  fl_head_q;
    logic [ROB_W-1:0]  fl_tail_q;
    logic [ROB_W-1:0]  rob_idx_q;
    logic              alloc;
    logic [PHYS_W-1:0] new_tag;
    logic [PHYS_W-1:0] prev_tag;

    // x0 never allocates, so tag 0 stays pinned to it
    assign alloc    = dec.valid && dec.writes_rd;
    assign new_tag  = free_q[fl_head_q];
    assign prev_tag = map_q[dec.rd];

    // map table and free list
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CORE_ARCH_REGS; i++) begin
                map_q[i] <= PHYS_W'(i); // identity mapping
            end
            for (int i = 0; i < `CORE_ROB_DEPTH; i++) begin
                free_q[i] <= PHYS_W'(`CORE_ARCH_REGS + i);
            end
            fl_head_q <= '0;
            fl_tail_q <= '0;
        end else begin
            if (alloc) begin
                map_q[dec.rd] <= new_tag;
                fl_head_q     <= fl_head_q + 1'b1;
            end
            if (release_tag.valid) begin
                free_q[fl_tail_q] <= release_tag.tag;
                fl_tail_q         <= fl_tail_q + 1'b1;
            end
        end
    end

    // renamed uop and buffer numbering
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            uop       <= '0;
            rob_idx_q <= '0;
        end else begin
            uop.valid     <= dec.valid;
            uop.pc        <= dec.pc;
            uop.alu_op    <= dec.alu_op;
            uop.uses_imm  <= dec.uses_imm;
            uop.imm       <= dec.imm;
            uop.prs1      <= map_q[dec.rs1];
            uop.prs2      <= map_q[dec.rs2];
            uop.prd       <= alloc ? new_tag : '0;
            uop.old_prd   <= alloc ? prev_tag : '0; // freed when this one retires
            uop.writes_rd <= dec.writes_rd;
            uop.rd        <= dec.rd;
            uop.rob_idx   <= rob_idx_q;
            if (dec.valid) begin
                rob_idx_q <= rob_idx_q + 1'b1;
            end
        end
    end

endmodule

//--- hdl/execute_stage.sv
`include "core_settings.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  core_pkg::ren_uop_t    uop,
    output core_pkg::exe_result_t result
);
    localparam int unsigned XLEN = `CORE_XLEN;

    logic [XLEN-1:0] prf_q [`CORE_PHYS_REGS];
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;
    logic            writes;

    // write lands at the edge, so the next uop reads it without a bypass
    assign op_a   = prf_q[uop.prs1];
    assign op_b   = uop.uses_imm ? uop.imm : prf_q[uop.prs2];
    assign shamt  = op_b[4:0];
    assign writes = uop.valid && uop.writes_rd;

    always_comb begin
        case (uop.alu_op)
            core_pkg::ALU_ADD: begin
                alu_out = op_a + op_b;
            end
            core_pkg::ALU_SUB: begin
                alu_out = op_a - op_b;
            end
            core_pkg::ALU_SLL: begin
                alu_out = op_a << shamt;
            end
            core_pkg::ALU_SLT: begin
                alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            core_pkg::ALU_SLTU: begin
                alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            end
            core_pkg::ALU_XOR: begin
                alu_out = op_a ^ op_b;
            end
            core_pkg::ALU_SRL: begin
                alu_out = op_a >> shamt;
            end
            core_pkg::ALU_SRA: begin
                alu_out = $unsigned($signed(op_a) >>> shamt);
            end
            core_pkg::ALU_OR: begin
                alu_out = op_a | op_b;
            end
            core_pkg::ALU_AND: begin
                alu_out = op_a & op_b;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // physical file, all zero out of reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CORE_PHYS_REGS; i++) begin
                prf_q[i] <= '0;
            end
        end else if (writes) begin
            prf_q[uop.prd] <= alu_out;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result <= '0;
        end else begin
            result.valid   <= uop.valid;
            result.rob_idx <= uop.rob_idx;
            result.value   <= uop.writes_rd ? alu_out : '0; // rd zero reports zero
        end
    end

endmodule

//--- hdl/reorder_buffer.sv
`include "core_settings.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rstn,
    input  core_pkg::ren_uop_t    alloc,
    input  core_pkg::exe_result_t result,
    output core_pkg::retire_t     retire,
    output core_pkg::free_t       release_tag
);
    localparam int unsigned DEPTH = `CORE_ROB_DEPTH;

    logic [`CORE_XLEN-1:0]   pc_q [DEPTH];
    logic [`CORE_ARCH_W-1:0] rd_q [DEPTH];
    logic [`CORE_PHYS_W-1:0] old_prd_q [DEPTH];
    logic [`CORE_XLEN-1:0]   value_q [DEPTH];
    logic [DEPTH-1:0]        writes_q;
    logic [DEPTH-1:0]        done_q;
    logic [`CORE_ROB_W-1:0]  head_q;
    logic                    head_done;

    // entries are numbered by rename, so head just follows that order
    assign head_done = done_q[head_q];

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            pc_q[alloc.rob_idx]      <= alloc.pc;
            rd_q[alloc.rob_idx]      <= alloc.rd;
            writes_q[alloc.rob_idx]  <= alloc.writes_rd;
            old_prd_q[alloc.rob_idx] <= alloc.old_prd;
        end
        if (result.valid) begin
            value_q[result.rob_idx] <= result.value;
        end
    end

    // completion flags, head and retire port
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done_q      <= '0;
            head_q      <= '0;
            retire      <= '0;
            release_tag <= '0;
        end else begin
            retire.valid      <= head_done;
            release_tag.valid <= head_done && writes_q[head_q];
            if (head_done) begin
                retire.pc        <= pc_q[head_q];
                retire.rd        <= rd_q[head_q];
                retire.writes_rd <= writes_q[head_q];
                retire.value     <= value_q[head_q];
                release_tag.tag  <= old_prd_q[head_q]; // back to the free list
                done_q[head_q]   <= 1'b0;
                head_q           <= head_q + 1'b1;
            end
            if (alloc.valid) begin
                done_q[alloc.rob_idx] <= 1'b0;
            end
            if (result.valid) begin
                done_q[result.rob_idx] <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/ooo_core.sv
module ooo_core (
    input  logic              clk,
    input  logic              rstn,
    input  logic              instr_valid,
    input  core_pkg::instr_t  instr,
    output core_pkg::retire_t retire
);
    core_pkg::dec_uop_t    dec_uop;
    core_pkg::ren_uop_t    ren_uop;
    core_pkg::exe_result_t exe_result;
    core_pkg::free_t       release_tag;

    decode_stage i_decode (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .uop         (dec_uop)
    );

    // tags come back from retirement
    rename_stage i_rename (
        .clk         (clk),
        .rstn        (rstn),
        .dec         (dec_uop),
        .release_tag (release_tag),
        .uop         (ren_uop)
    );

    execute_stage i_execute (
        .clk    (clk),
        .rstn   (rstn),
        .uop    (ren_uop),
        .result (exe_result)
    );

    reorder_buffer i_rob (
        .clk         (clk),
        .rstn        (rstn),
        .alloc       (ren_uop),
        .result      (exe_result),
        .retire      (retire),
        .release_tag (release_tag)
    );

endmodule

//--- bench/tb_ooo_core.sv
`include "core_settings.svh"

module tb_ooo_core;

    localparam int RETIRE_TIMEOUT = 20;
    localparam int RANDOM_COUNT   = 400;
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111; // outside the supported subset

    logic              clk;
    logic              rstn;
    logic              instr_valid;
    core_pkg::instr_t  instr;
    core_pkg::retire_t retire;

    string             t_name [$];
    core_pkg::instr_t  t_word [$];
    bit                t_retires [$];
    bit                t_chain [$]; // next entry follows without a gap
    logic [4:0]        t_rd [$];
    logic [31:0]       t_value [$];

    // retirements still outstanding, oldest first
    core_pkg::retire_t q_exp [$];
    string             q_name [$];
    int                q_cyc [$];
    bit                q_report [$];

    logic [31:0] shadow [`CORE_ARCH_REGS];
    logic [31:0] pc_model;
    logic [31:0] lfsr;
    int          cyc;
    int          errors;
    int          n_ok;
    int          n_bad;

    ooo_core i_dut (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic core_pkg::instr_t r_op(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        core_pkg::instr_t w;
        w.r_view = {f7, rs2, rs1, f3, rd, OP_REG};
        return w;
    endfunction

    function automatic core_pkg::instr_t i_op(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
        core_pkg::instr_t w;
        w.i_view = {imm, rs1, f3, rd, OP_IMM};
        return w;
    endfunction

    // galois lfsr, stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // rv32i alu behavior by funct3
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                r = a >> b[4:0];
                if (alt && a[31]) begin
                    r = r | ~(32'hffff_ffff >> b[4:0]); // sign fill
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic check_retire(input string name, input core_pkg::retire_t exp,
                                input core_pkg::retire_t act, output bit ok);
        ok = 1'b1;
        if (act.pc !== exp.pc) begin
            $display("Mismatch %s pc: expected %h, actual %h", name, exp.pc, act.pc);
            ok = 1'b0;
        end
        if (act.rd !== exp.rd) begin
            $display("Mismatch %s rd: expected %0d, actual %0d", name, exp.rd, act.rd);
            ok = 1'b0;
        end
        if (act.writes_rd !== exp.writes_rd) begin
            $display("Mismatch %s writes_rd: expected %b, actual %b", name, exp.writes_rd,
                     act.writes_rd);
            ok = 1'b0;
        end
        if (act.value !== exp.value) begin
            $display("Mismatch %s value: expected %h, actual %h", name, exp.value, act.value);
            ok = 1'b0;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act, output bit ok);
        ok = (act == exp);
        if (!ok) begin
            $display("Mismatch %s latency: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report(input string name, input bit ok);
        if (ok) begin
            n_ok++;
            $display("%s ok", name);
        end else begin
            n_bad++;
            $display("%s wrong", name);
        end
    endtask

    task automatic drop_front();
        void'(q_exp.pop_front());
        void'(q_name.pop_front());
        void'(q_cyc.pop_front());
        void'(q_report.pop_front());
    endtask

    // one clock, retire port looked at just after the edge
    task automatic tick(input logic v, input core_pkg::instr_t w);
        bit ok_r;
        bit ok_l;
        instr_valid = v;
        instr       = w;
        @(posedge clk);
        #1;
        cyc++;
        if (retire.valid === 1'b1) begin
            if (q_exp.size() == 0) begin
                $display("instruction retired with nothing pending, pc %h", retire.pc);
                errors++;
            end else begin
                check_retire(q_name[0], q_exp[0], retire, ok_r);
                check_latency(q_name[0], 4, cyc - q_cyc[0], ok_l);
                if (!(ok_r && ok_l)) begin
                    errors++;
                end
                if (q_report[0]) begin
                    report(q_name[0], ok_r && ok_l);
                end
                drop_front();
            end
        end
    endtask

    task automatic issue(input string name, input core_pkg::instr_t w, input bit retires,
                         input logic [4:0] rd, input logic [31:0] value, input bit rep);
        core_pkg::retire_t exp;
        exp           = '0;
        exp.valid     = 1'b1;
        exp.pc        = pc_model;
        exp.rd        = rd;
        exp.writes_rd = (rd != 5'd0);
        exp.value     = value;
        if (retires) begin
            q_exp.push_back(exp);
            q_name.push_back(name);
            q_cyc.push_back(cyc + 1);
            q_report.push_back(rep);
        end
        pc_model += 32'd4; // skipped words use a slot too
        tick(1'b1, w);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (q_exp.size() > 0 && waited < RETIRE_TIMEOUT) begin
            tick(1'b0, '0);
            waited++;
        end
        if (q_exp.size() > 0) begin
            $display("no instruction retired within %0d cycles, %s still pending",
                     RETIRE_TIMEOUT, q_name[0]);
            errors++;
            while (q_exp.size() > 0) begin
                if (q_report[0]) begin
                    report(q_name[0], 1'b0);
                end
                drop_front();
            end
        end
    endtask

    task automatic add_test(input string name, input core_pkg::instr_t w, input bit retires,
                            input bit chain, input logic [4:0] rd, input logic [31:0] value);
        t_name.push_back(name);
        t_word.push_back(w);
        t_retires.push_back(retires);
        t_chain.push_back(chain);
        t_rd.push_back(rd);
        t_value.push_back(value);
    endtask

    task automatic build_table();
        add_test("addi_pos", i_op(12'h123, 5'd0, 3'd0, 5'd1), 1, 0, 5'd1, 32'h0000_0123);
        add_test("addi_neg", i_op(12'hffb, 5'd0, 3'd0, 5'd2), 1, 0, 5'd2, 32'hffff_fffb);
        add_test("add", r_op(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1, 0, 5'd3, 32'h0000_011e);
        add_test("sub", r_op(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1, 0, 5'd4, 32'h0000_0128);
        add_test("and", r_op(7'h00, 5'd2, 5'd1, 3'd7, 5'd5), 1, 0, 5'd5, 32'h0000_0123);
        add_test("or", r_op(7'h00, 5'd2, 5'd1, 3'd6, 5'd6), 1, 0, 5'd6, 32'hffff_fffb);
        add_test("xor", r_op(7'h00, 5'd2, 5'd1, 3'd4, 5'd7), 1, 0, 5'd7, 32'hffff_fed8);
        add_test("slt", r_op(7'h00, 5'd1, 5'd2, 3'd2, 5'd8), 1, 0, 5'd8, 32'd1);
        add_test("sltu", r_op(7'h00, 5'd1, 5'd2, 3'd3, 5'd9), 1, 0, 5'd9, 32'd0);
        add_test("sll", r_op(7'h00, 5'd3, 5'd1, 3'd1, 5'd10), 1, 0, 5'd10, 32'hc000_0000);
        add_test("srl", r_op(7'h00, 5'd1, 5'd2, 3'd5, 5'd11), 1, 0, 5'd11, 32'h1fff_ffff);
        add_test("sra", r_op(7'h20, 5'd1, 5'd2, 3'd5, 5'd12), 1, 0, 5'd12, 32'hffff_ffff);
        add_test("andi", i_op(12'h0f0, 5'd2, 3'd7, 5'd13), 1, 0, 5'd13, 32'h0000_00f0);
        add_test("ori", i_op(12'h800, 5'd1, 3'd6, 5'd14), 1, 0, 5'd14, 32'hffff_f923);
        add_test("xori", i_op(12'hfff, 5'd1, 3'd4, 5'd15), 1, 0, 5'd15, 32'hffff_fedc);
        add_test("slti", i_op(12'hffc, 5'd2, 3'd2, 5'd16), 1, 0, 5'd16, 32'd1);
        add_test("sltiu", i_op(12'hfff, 5'd1, 3'd3, 5'd17), 1, 0, 5'd17, 32'd1);
        add_test("slli", i_op(12'h004, 5'd1, 3'd1, 5'd18), 1, 0, 5'd18, 32'h0000_1230);
        add_test("srli", i_op(12'h01c, 5'd2, 3'd5, 5'd19), 1, 0, 5'd19, 32'h0000_000f);
        add_test("srai", i_op(12'h401, 5'd2, 3'd5, 5'd20), 1, 0, 5'd20, 32'hffff_fffd);
        add_test("rd_zero", i_op(12'h007, 5'd1, 3'd0, 5'd0), 1, 0, 5'd0, 32'd0);
        add_test("read_x0", r_op(7'h00, 5'd1, 5'd0, 3'd0, 5'd21), 1, 0, 5'd21, 32'h0000_0123);
        add_test("illegal", 32'h0000_0073, 0, 0, 5'd0, 32'd0); // system opcode
        add_test("after_skip", i_op(12'h001, 5'd0, 3'd0, 5'd22), 1, 0, 5'd22, 32'd1);
        add_test("chain_0", i_op(12'h001, 5'd0, 3'd0, 5'd23), 1, 1, 5'd23, 32'd1);
        add_test("chain_1", r_op(7'h00, 5'd23, 5'd23, 3'd0, 5'd23), 1, 1, 5'd23, 32'd2);
        add_test("chain_2", i_op(12'h003, 5'd23, 3'd1, 5'd23), 1, 1, 5'd23, 32'd16);
        add_test("chain_3", r_op(7'h20, 5'd1, 5'd23, 3'd0, 5'd23), 1, 1, 5'd23, 32'hffff_feed);
        add_test("chain_4", i_op(12'h404, 5'd23, 3'd5, 5'd23), 1, 1, 5'd23, 32'hffff_ffee);
        add_test("chain_5", i_op(12'hfff, 5'd23, 3'd4, 5'd23), 1, 0, 5'd23, 32'h0000_0011);
    endtask

    initial begin
        int               err0;
        logic             alt;
        logic             alt_eff;
        logic [2:0]       f3;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [11:0]      imm;
        logic [31:0]      b;
        logic [31:0]      v;
        core_pkg::instr_t w;
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc_model    = '0;
        lfsr        = 32'h2cd8_65a2;
        cyc         = 0;
        errors      = 0;
        n_ok        = 0;
        n_bad       = 0;
        for (int i = 0; i < `CORE_ARCH_REGS; i++) begin
            shadow[i] = '0;
        end
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        err0 = errors;
        repeat (6) tick(1'b0, '0); // quiet until the first strobe
        report("reset_idle", errors == err0);

        for (int i = 0; i < t_name.size(); i++) begin
            err0 = errors;
            issue(t_name[i], t_word[i], t_retires[i], t_rd[i], t_value[i], 1'b1);
            if (t_retires[i] && t_rd[i] != 5'd0) begin
                shadow[t_rd[i]] = t_value[i]; // random run carries on from here
            end
            if (!t_retires[i]) begin
                repeat (6) tick(1'b0, '0);
                report(t_name[i], errors == err0);
            end else if (!t_chain[i]) begin
                drain();
            end
        end

        err0 = errors;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            if (take_bits(2) == 0) begin
                tick(1'b0, '0);
            end
            rd  = take_bits(5);
            rs1 = take_bits(5);
            rs2 = take_bits(5);
            f3  = take_bits(3);
            alt = take_bits(1);
            imm = take_bits(12);
            if (take_bits(4) == 0) begin
                w               = '0;
                w.r_view.opcode = OP_LUI;
                w.r_view.rd     = rd;
                issue($sformatf("rand_%0d", n), w, 1'b0, rd, '0, 1'b0);
            end else begin
                if (take_bits(1) == 1) begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm[11:5] = (f3 == 3'd5 && alt) ? 7'h20 : 7'h00;
                    end
                    alt_eff = (f3 == 3'd5) && alt;
                    w       = i_op(imm, rs1, f3, rd);
                    b       = {{20{imm[11]}}, imm};
                end else begin
                    alt_eff = alt && (f3 == 3'd0 || f3 == 3'd5);
                    w       = r_op(alt_eff ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
                    b       = shadow[rs2];
                end
                v = (rd == 5'd0) ? '0 : ref_alu(f3, alt_eff, shadow[rs1], b);
                if (rd != 5'd0) begin
                    shadow[rd] = v;
                end
                issue($sformatf("rand_%0d", n), w, 1'b1, rd, v, 1'b0);
            end
        end
        drain();
        report("random_run", errors == err0);

        $display("%0d tests ok, %0d tests wrong, %0d errors", n_ok, n_bad, errors);
        if (errors == 0 && n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/decode_stage.sv
hdl/rename_stage.sv
hdl/execute_stage.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
bench/tb_ooo_core.sv

//--- Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - hdl

sources:
  - hdl/core_pkg.sv
  - hdl/decode_stage.sv
  - hdl/rename_stage.sv
  - hdl/execute_stage.sv
  - hdl/reorder_buffer.sv
  - hdl/ooo_core.sv
  - target: simulation
    files:
      - bench/tb_ooo_core.sv
